//--- src/fgyrus_pkg.sv
/* Shared definitions for the FFT sequencer
   Sample type, controller phase enum, post-normalization codes and shift lookup */
`default_nettype none

package fgyrus_pkg;

  localparam int DATA_W = 32;                 // One real or imaginary part

  typedef logic signed [DATA_W-1:0] sample_t;

  // Controller phase, also visible at the top level as the present state
  typedef enum logic [1:0] {
    IDLE_S     = 2'd0,
    DECIMATE_S = 2'd1,
    FFT_S      = 2'd2,
    OUTPUT_S   = 2'd3
  } fsm_state_e;

  // Post-normalization codes, named after the divisor
  typedef enum logic [3:0] {
    NORM_NONE  = 4'd0,
    NORM_16    = 4'd1,
    NORM_128   = 4'd2,
    NORM_256   = 4'd3,
    NORM_4096  = 4'd4,
    NORM_65536 = 4'd5
  } post_norm_e;

  // Right shift for a normalization code, unknown codes pass data unshifted
  function automatic logic [4:0] norm_shift(post_norm_e code);
    case (code)
      NORM_NONE:  return 5'd0;
      NORM_16:    return 5'd4;
      NORM_128:   return 5'd7;
      NORM_256:   return 5'd8;
      NORM_4096:  return 5'd12;
      NORM_65536: return 5'd16;
      default:    return 5'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- src/cache_port_if.sv
/* Read and write access of one client to the FFT cache */
`timescale 1ns/10ps
`default_nettype none

interface cache_port_if #(
  parameter int NO_SAMPLES = 128
);

  import fgyrus_pkg::*;

  localparam int AW = $clog2(NO_SAMPLES);

  logic [AW-1:0] rd_addr;   // Data shows up one cycle later
  sample_t       rd_real;
  sample_t       rd_im;

  logic          wr_en;
  logic [AW-1:0] wr_addr;
  sample_t       wr_real;
  sample_t       wr_im;

  // Client side drives addresses and write data
  modport client (
    output rd_addr, wr_en, wr_addr, wr_real, wr_im,
    input  rd_real, rd_im
  );

  // Cache side answers with registered read data
  modport cache (
    input  rd_addr, wr_en, wr_addr, wr_real, wr_im,
    output rd_real, rd_im
  );

endinterface

`default_nettype wire

//--- src/fgyrus_ctrl.sv
/* Phase sequencing FSM with the busy and done status outputs */
`timescale 1ns/10ps
`default_nettype none

module fgyrus_ctrl (
  input  wire                    clk_ir,
  input  wire                    rst_il,
  input  wire logic              fgyrus_en,
  input  wire logic              pcm_rdy,
  input  wire logic              load_done,    // From the PCM loader
  input  wire logic              stages_done,  // From the butterfly sequencer
  input  wire logic              out_done,     // From the result writer
  output fgyrus_pkg::fsm_state_e phase,
  output logic                   busy,
  output logic                   fft_done,
  output logic                   pcm_done
);

  import fgyrus_pkg::*;

  fsm_state_e next_phase;

  // Each phase ends on the strobe of the worker that owns it
  always_comb
  begin
    next_phase = phase;
    case (phase)
      IDLE_S:
        if (pcm_rdy && fgyrus_en)
          next_phase = DECIMATE_S;
      DECIMATE_S:
        if (load_done)
          next_phase = FFT_S;
      FFT_S:
        if (stages_done)
          next_phase = OUTPUT_S;
      OUTPUT_S:
        if (out_done)
          next_phase = IDLE_S;
      default:
        next_phase = IDLE_S;
    endcase
  end

  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      phase    <= IDLE_S;
      busy     <= 1'b0;
      fft_done <= 1'b0;
      pcm_done <= 1'b0;
    end
    else
    begin
      phase    <= next_phase;
      busy     <= (next_phase != IDLE_S);          // Drops on the edge back to idle
      fft_done <= (phase == FFT_S) && stages_done;
      pcm_done <= (phase == OUTPUT_S) && out_done;
    end
  end

endmodule

`default_nettype wire

//--- src/pcm_loader.sv
/* Bit-reversed PCM RAM read and sequential fill of the FFT cache */
`timescale 1ns/10ps
`default_nettype none

module pcm_loader #(
  parameter int NO_SAMPLES = 128,
  parameter int RAM_RD_LAT = 2
) (
  input  wire                           clk_ir,
  input  wire                           rst_il,
  input  wire fgyrus_pkg::fsm_state_e   phase,
  output logic [$clog2(NO_SAMPLES)-1:0] pcm_rd_addr,
  input  wire fgyrus_pkg::sample_t      pcm_rd_data,
  output logic                          load_done,
  cache_port_if.client                  cache
);

  import fgyrus_pkg::*;

  localparam int AW = $clog2(NO_SAMPLES);

  logic [AW:0]           rd_cnt;   // MSB set once all reads are issued
  logic                  rd_issue;
  logic [RAM_RD_LAT-1:0] vld_sr;   // Tracks reads still in flight in the RAM
  logic [AW-1:0]         wr_cnt;

  assign rd_issue = (phase == DECIMATE_S) && !rd_cnt[AW];

  // PCM address is the sample counter with its bits mirrored
  always_comb
  begin
    for (int b = 0; b < AW; b++)
      pcm_rd_addr[b] = rd_cnt[AW-1-b];
  end

  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      rd_cnt    <= '0;
      vld_sr    <= '0;
      wr_cnt    <= '0;
      load_done <= 1'b0;
    end
    else if (phase != DECIMATE_S)
    begin
      rd_cnt    <= '0;
      vld_sr    <= '0;
      wr_cnt    <= '0;
      load_done <= 1'b0;
    end
    else
    begin
      rd_cnt    <= rd_cnt + rd_issue;
      vld_sr[0] <= rd_issue;
      for (int i = 1; i < RAM_RD_LAT; i++)
        vld_sr[i] <= vld_sr[i-1];
      if (cache.wr_en)
        wr_cnt <= wr_cnt + 1'b1;
      load_done <= cache.wr_en && (&wr_cnt);       // Cycle after the last write
    end
  end

  assign cache.rd_addr = '0;                       // Loader never reads the cache
  assign cache.wr_en   = vld_sr[RAM_RD_LAT-1];
  assign cache.wr_addr = wr_cnt;
  assign cache.wr_real = pcm_rd_data;
  assign cache.wr_im   = '0;                       // PCM input is purely real

endmodule

`default_nettype wire

//--- src/butterfly_seq.sv
/* In-place radix-2 stage walker with a Wishbone classic butterfly master
   Reads each pair from the cache, sends it out and writes both results back */
`timescale 1ns/10ps
`default_nettype none

module butterfly_seq #(
  parameter int NO_SAMPLES = 128
) (
  input  wire                         clk_ir,
  input  wire                         rst_il,
  input  wire fgyrus_pkg::fsm_state_e phase,
  output logic                        stages_done,
  cache_port_if.client                cache,

  output logic                        bfly_cyc,
  output logic                        bfly_stb,
  output fgyrus_pkg::sample_t         bfly_a_real,
  output fgyrus_pkg::sample_t         bfly_a_im,
  output fgyrus_pkg::sample_t         bfly_b_real,
  output fgyrus_pkg::sample_t         bfly_b_im,
  input  wire                         bfly_ack,
  input  wire fgyrus_pkg::sample_t    bfly_a_real_res,
  input  wire fgyrus_pkg::sample_t    bfly_a_im_res,
  input  wire fgyrus_pkg::sample_t    bfly_b_real_res,
  input  wire fgyrus_pkg::sample_t    bfly_b_im_res
);

  import fgyrus_pkg::*;

  localparam int AW = $clog2(NO_SAMPLES);
  localparam int SW = $clog2(AW);

  typedef enum logic [2:0] {
    BF_RD_A,   // Present address of A, also the rest state
    BF_RD_B,   // Present address of B, A comes back
    BF_BUS,    // Wishbone cycle, held until ack
    BF_WR_A,
    BF_WR_B,
    BF_FIN     // All stages done, wait for the phase to move on
  } bf_state_e;

  bf_state_e     state;
  logic [SW-1:0] stage;
  logic [AW-2:0] group;
  logic [AW-2:0] offset;
  logic [AW-1:0] span;       // 2 to the power stage
  logic [AW-1:0] idx_a;
  logic [AW-1:0] idx_b;
  logic          offset_last;
  logic          pair_last;
  logic          stage_last;
  sample_t       a_real_q;
  sample_t       a_im_q;
  sample_t       b_real_q;
  sample_t       b_im_q;

  // Insert a zero at bit position stage, A and B differ only in that bit
  assign span        = AW'(1) << stage;
  assign idx_a       = ({group, 1'b0} << stage) | {1'b0, offset};
  assign idx_b       = idx_a | span;
  assign offset_last = ({1'b0, offset} == span - 1'b1);
  assign pair_last   = &idx_b;                     // B lands on the top entry
  assign stage_last  = (stage == SW'(AW - 1));

  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      state       <= BF_RD_A;
      stage       <= '0;
      group       <= '0;
      offset      <= '0;
      bfly_cyc    <= 1'b0;
      bfly_stb    <= 1'b0;
      stages_done <= 1'b0;
    end
    else
    begin
      stages_done <= 1'b0;
      case (state)
        BF_RD_A:
          if (phase == FFT_S)
            state <= BF_RD_B;
        BF_RD_B:
        begin
          bfly_cyc <= 1'b1;
          bfly_stb <= 1'b1;
          state    <= BF_BUS;
        end
        BF_BUS:
          if (bfly_ack)
          begin
            bfly_cyc <= 1'b0;
            bfly_stb <= 1'b0;
            state    <= BF_WR_A;
          end
        BF_WR_A:
          state <= BF_WR_B;
        BF_WR_B:
        begin
          if (pair_last)
          begin
            group  <= '0;
            offset <= '0;
            stage  <= stage_last ? '0 : stage + 1'b1;
          end
          else if (offset_last)
          begin
            offset <= '0;
            group  <= group + 1'b1;
          end
          else
            offset <= offset + 1'b1;
          stages_done <= pair_last && stage_last;
          state       <= (pair_last && stage_last) ? BF_FIN : BF_RD_A;
        end
        BF_FIN:
          if (phase != FFT_S)
            state <= BF_RD_A;
        default:
          state <= BF_RD_A;
      endcase
    end
  end

  // A is registered, results are captured in the ack cycle
  always_ff @(posedge clk_ir)
  begin
    if (state == BF_RD_B)
    begin
      bfly_a_real <= cache.rd_real;
      bfly_a_im   <= cache.rd_im;
    end
    if (state == BF_BUS && bfly_ack)
    begin
      a_real_q <= bfly_a_real_res;
      a_im_q   <= bfly_a_im_res;
      b_real_q <= bfly_b_real_res;
      b_im_q   <= bfly_b_im_res;
    end
  end

  // B comes straight from the cache read register, held while rd_addr stays on B
  assign bfly_b_real = cache.rd_real;
  assign bfly_b_im   = cache.rd_im;

  assign cache.rd_addr = (state == BF_RD_A) ? idx_a : idx_b;
  assign cache.wr_en   = (state == BF_WR_A) || (state == BF_WR_B);
  assign cache.wr_addr = (state == BF_WR_A) ? idx_a : idx_b;
  assign cache.wr_real = (state == BF_WR_A) ? a_real_q : b_real_q;
  assign cache.wr_im   = (state == BF_WR_A) ? a_im_q : b_im_q;

endmodule

`default_nettype wire

//--- src/fft_cache.sv
/* Complex FFT sample memory with registered read
   Phase picks the client that owns the addresses and write enable */
`timescale 1ns/10ps
`default_nettype none

module fft_cache #(
  parameter int NO_SAMPLES = 128
) (
  input  wire                         clk_ir,
  input  wire fgyrus_pkg::fsm_state_e phase,
  cache_port_if.cache                 load_port,
  cache_port_if.cache                 fft_port,
  cache_port_if.cache                 out_port
);

  import fgyrus_pkg::*;

  localparam int AW = $clog2(NO_SAMPLES);

  sample_t       mem_real [NO_SAMPLES];
  sample_t       mem_im [NO_SAMPLES];
  sample_t       rd_real_q;
  sample_t       rd_im_q;
  logic [AW-1:0] rd_addr;
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  sample_t       wr_real;
  sample_t       wr_im;

  always_comb
  begin
    rd_addr = '0;
    wr_en   = 1'b0;                                // No writes while idle
    wr_addr = '0;
    wr_real = '0;
    wr_im   = '0;
    case (phase)
      DECIMATE_S:
      begin
        rd_addr = load_port.rd_addr;
        wr_en   = load_port.wr_en;
        wr_addr = load_port.wr_addr;
        wr_real = load_port.wr_real;
        wr_im   = load_port.wr_im;
      end
      FFT_S:
      begin
        rd_addr = fft_port.rd_addr;
        wr_en   = fft_port.wr_en;
        wr_addr = fft_port.wr_addr;
        wr_real = fft_port.wr_real;
        wr_im   = fft_port.wr_im;
      end
      OUTPUT_S:
      begin
        rd_addr = out_port.rd_addr;
        wr_en   = out_port.wr_en;
        wr_addr = out_port.wr_addr;
        wr_real = out_port.wr_real;
        wr_im   = out_port.wr_im;
      end
      default:
        wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk_ir)
  begin
    if (wr_en)
    begin
      mem_real[wr_addr] <= wr_real;
      mem_im[wr_addr]   <= wr_im;
    end
    rd_real_q <= mem_real[rd_addr];                // Old data on a same-address write
    rd_im_q   <= mem_im[rd_addr];
  end

  // Every client sees the same read data
  assign load_port.rd_real = rd_real_q;
  assign load_port.rd_im   = rd_im_q;
  assign fft_port.rd_real  = rd_real_q;
  assign fft_port.rd_im    = rd_im_q;
  assign out_port.rd_real  = rd_real_q;
  assign out_port.rd_im    = rd_im_q;

endmodule

`default_nettype wire

//--- src/result_writer.sv
/* Cache readout in address order, post-normalization and result RAM writes */
`timescale 1ns/10ps
`default_nettype none

module result_writer #(
  parameter int NO_SAMPLES = 128
) (
  input  wire                           clk_ir,
  input  wire                           rst_il,
  input  wire fgyrus_pkg::fsm_state_e   phase,
  input  wire logic [3:0]               post_norm,
  output logic                          out_done,
  cache_port_if.client                  cache,
  output logic                          res_wr_en,
  output logic [$clog2(NO_SAMPLES)-1:0] res_wr_addr,
  output fgyrus_pkg::sample_t           res_wr_data
);

  import fgyrus_pkg::*;

  localparam int AW = $clog2(NO_SAMPLES);

  logic [AW:0]   rd_cnt;     // MSB set once every entry is read
  logic          rd_issue;
  logic          rd_vld;     // Cache data valid this cycle
  logic [AW-1:0] rd_addr_q;
  logic [4:0]    shift;

  assign rd_issue = (phase == OUTPUT_S) && !rd_cnt[AW];
  assign shift    = norm_shift(post_norm_e'(post_norm));

  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      rd_cnt    <= '0;
      rd_vld    <= 1'b0;
      res_wr_en <= 1'b0;
    end
    else
    begin
      rd_cnt    <= (phase == OUTPUT_S) ? rd_cnt + rd_issue : '0;
      rd_vld    <= rd_issue;
      res_wr_en <= rd_vld;
    end
  end

  // Logical shift of the real part, unsigned as in the result RAM
  always_ff @(posedge clk_ir)
  begin
    rd_addr_q   <= cache.rd_addr;
    res_wr_addr <= rd_addr_q;
    res_wr_data <= sample_t'($unsigned(cache.rd_real) >> shift);
  end

  assign out_done = res_wr_en && (&res_wr_addr);   // Same cycle as the last write

  assign cache.rd_addr = rd_cnt[AW-1:0];
  assign cache.wr_en   = 1'b0;                     // Output side is read only
  assign cache.wr_addr = '0;
  assign cache.wr_real = '0;
  assign cache.wr_im   = '0;

endmodule

`default_nettype wire

//--- src/fgyrus_top.sv
/* FFT sequencer top level
   Control FSM, PCM loader, butterfly sequencer, result writer and cache */
`timescale 1ns/10ps
`default_nettype none

module fgyrus_top #(
  parameter int NO_SAMPLES = 128,
  parameter int RAM_RD_LAT = 2
) (
  input  wire                           clk_ir,
  input  wire                           rst_il,

  input  wire logic                     fgyrus_en,
  input  wire logic                     pcm_rdy,
  input  wire logic [3:0]               post_norm,
  output logic                          busy,
  output logic                          fft_done,
  output logic                          pcm_done,
  output fgyrus_pkg::fsm_state_e        pstate,

  output logic [$clog2(NO_SAMPLES)-1:0] pcm_rd_addr,
  input  wire fgyrus_pkg::sample_t      pcm_rd_data,

  output logic                          bfly_cyc,
  output logic                          bfly_stb,
  output fgyrus_pkg::sample_t           bfly_a_real,
  output fgyrus_pkg::sample_t           bfly_a_im,
  output fgyrus_pkg::sample_t           bfly_b_real,
  output fgyrus_pkg::sample_t           bfly_b_im,
  input  wire                           bfly_ack,
  input  wire fgyrus_pkg::sample_t      bfly_a_real_res,
  input  wire fgyrus_pkg::sample_t      bfly_a_im_res,
  input  wire fgyrus_pkg::sample_t      bfly_b_real_res,
  input  wire fgyrus_pkg::sample_t      bfly_b_im_res,

  output logic                          res_wr_en,
  output logic [$clog2(NO_SAMPLES)-1:0] res_wr_addr,
  output fgyrus_pkg::sample_t           res_wr_data
);

  import fgyrus_pkg::*;

  fsm_state_e phase;        // Active phase, seen by every worker
  logic       load_done;
  logic       stages_done;
  logic       out_done;

  cache_port_if #(.NO_SAMPLES(NO_SAMPLES)) load_if ();
  cache_port_if #(.NO_SAMPLES(NO_SAMPLES)) fft_if ();
  cache_port_if #(.NO_SAMPLES(NO_SAMPLES)) out_if ();

  assign pstate = phase;

  fgyrus_ctrl i_ctrl (
    .clk_ir      (clk_ir),
    .rst_il      (rst_il),
    .fgyrus_en   (fgyrus_en),
    .pcm_rdy     (pcm_rdy),
    .load_done   (load_done),
    .stages_done (stages_done),
    .out_done    (out_done),
    .phase       (phase),
    .busy        (busy),
    .fft_done    (fft_done),
    .pcm_done    (pcm_done)
  );

  pcm_loader #(
    .NO_SAMPLES (NO_SAMPLES),
    .RAM_RD_LAT (RAM_RD_LAT)
  ) i_loader (
    .clk_ir      (clk_ir),
    .rst_il      (rst_il),
    .phase       (phase),
    .pcm_rd_addr (pcm_rd_addr),
    .pcm_rd_data (pcm_rd_data),
    .load_done   (load_done),
    .cache       (load_if)
  );

  butterfly_seq #(.NO_SAMPLES(NO_SAMPLES)) i_bfly_seq (
    .clk_ir          (clk_ir),
    .rst_il          (rst_il),
    .phase           (phase),
    .stages_done     (stages_done),
    .cache           (fft_if),
    .bfly_cyc        (bfly_cyc),
    .bfly_stb        (bfly_stb),
    .bfly_a_real     (bfly_a_real),
    .bfly_a_im       (bfly_a_im),
    .bfly_b_real     (bfly_b_real),
    .bfly_b_im       (bfly_b_im),
    .bfly_ack        (bfly_ack),
    .bfly_a_real_res (bfly_a_real_res),
    .bfly_a_im_res   (bfly_a_im_res),
    .bfly_b_real_res (bfly_b_real_res),
    .bfly_b_im_res   (bfly_b_im_res)
  );

  result_writer #(.NO_SAMPLES(NO_SAMPLES)) i_res_writer (
    .clk_ir      (clk_ir),
    .rst_il      (rst_il),
    .phase       (phase),
    .post_norm   (post_norm),
    .out_done    (out_done),
    .cache       (out_if),
    .res_wr_en   (res_wr_en),
    .res_wr_addr (res_wr_addr),
    .res_wr_data (res_wr_data)
  );

  fft_cache #(.NO_SAMPLES(NO_SAMPLES)) i_cache (
    .clk_ir    (clk_ir),
    .phase     (phase),
    .load_port (load_if),
    .fft_port  (fft_if),
    .out_port  (out_if)
  );

endmodule

`default_nettype wire

//--- sim/fgyrus_ref.svh
/* Reference model for the FFT sequencer testbench
   Bit reversal, butterfly arithmetic, normalization shift and reference FFT */
`ifndef FGYRUS_REF_SVH
`define FGYRUS_REF_SVH

// Uses N, LOG_N and sample_t of the including testbench

function automatic logic [LOG_N-1:0] bit_rev(input int k);
  logic [LOG_N-1:0] r;
  for (int b = 0; b < LOG_N; b++)
    r[b] = k[LOG_N-1-b];
  return r;
endfunction

// Butterfly of the external slave, plain sum and difference with 32-bit wrap
function automatic sample_t bfly_sum(input sample_t a, input sample_t b);
  return a + b;
endfunction

function automatic sample_t bfly_diff(input sample_t a, input sample_t b);
  return a - b;
endfunction

// Right shift per post-normalization code
function automatic int norm_bits(input logic [3:0] code);
  case (code)
    4'd1:    return 4;
    4'd2:    return 7;
    4'd3:    return 8;
    4'd4:    return 12;
    4'd5:    return 16;
    default: return 0;     // Code 0 and every undefined code
  endcase
endfunction

function automatic void ref_fft(input sample_t pcm [N], input logic [3:0] code,
                                output sample_t res [N]);
  sample_t re [N];
  sample_t im [N];
  sample_t tr;
  sample_t ti;
  int      h;
  for (int k = 0; k < N; k++)
  begin
    re[k] = pcm[bit_rev(k)];       // Cache entry k holds sample bit_rev(k)
    im[k] = '0;
  end
  for (int s = 0; s < LOG_N; s++)
  begin
    h = 1 << s;
    for (int i = 0; i < N; i++)
      if (((i >> s) & 1) == 0)     // i pairs with i+h
      begin
        tr      = re[i];
        ti      = im[i];
        re[i]   = bfly_sum(tr, re[i+h]);
        im[i]   = bfly_sum(ti, im[i+h]);
        re[i+h] = bfly_diff(tr, re[i+h]);
        im[i+h] = bfly_diff(ti, im[i+h]);
      end
  end
  for (int k = 0; k < N; k++)
    res[k] = $unsigned(re[k]) >> norm_bits(code);   // Logical shift
endfunction

`endif

//--- sim/fgyrus_tb.sv
/* FFT sequencer testbench
   Clock and reset, PCM RAM, butterfly slave, result RAM, checker and timeout */
`timescale 1ns/10ps
`default_nettype none

module fgyrus_tb;

  import fgyrus_pkg::*;

  localparam int N          = 128;
  localparam int LOG_N      = $clog2(N);
  localparam int RD_LAT     = 2;                       // Same as the DUT default
  localparam int RUN_CYCLES = N * LOG_N * 5 + 4 * N;   // Longest run with ack delay 3
  localparam int MAX_CYCLES = 6 * RUN_CYCLES + 1000;

  `include "fgyrus_ref.svh"

  logic             clk_ir;
  logic             rst_il;
  logic             fgyrus_en;
  logic             pcm_rdy;
  logic [3:0]       post_norm;
  logic             busy;
  logic             fft_done;
  logic             pcm_done;
  fsm_state_e       pstate;
  logic [LOG_N-1:0] pcm_rd_addr;
  sample_t          pcm_rd_data = '0;
  logic             bfly_cyc;
  logic             bfly_stb;
  sample_t          bfly_a_real;
  sample_t          bfly_a_im;
  sample_t          bfly_b_real;
  sample_t          bfly_b_im;
  logic             bfly_ack = 1'b0;
  sample_t          bfly_a_real_res = '0;
  sample_t          bfly_a_im_res = '0;
  sample_t          bfly_b_real_res = '0;
  sample_t          bfly_b_im_res = '0;
  logic             res_wr_en;
  logic [LOG_N-1:0] res_wr_addr;
  sample_t          res_wr_data;

  sample_t pcm_mem [N];
  sample_t rd_pipe [RD_LAT] = '{default: '0};
  sample_t res_mem [N];
  sample_t exp_res [N];
  sample_t held [4];               // Butterfly inputs seen at the start of a bus cycle

  integer seed         = 32'h9849;
  int     err_cnt      = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  int     cycle_cnt    = 0;
  int     runs_done    = 0;
  int     res_writes   = 0;
  int     fft_pulses   = 0;
  int     addr_seen    = 0;
  int     ack_wait     = 0;
  bit     ack_rand     = 1'b0;
  bit     in_tx        = 1'b0;

  fgyrus_top i_fgyrus_top (
    .clk_ir          (clk_ir),
    .rst_il          (rst_il),
    .fgyrus_en       (fgyrus_en),
    .pcm_rdy         (pcm_rdy),
    .post_norm       (post_norm),
    .busy            (busy),
    .fft_done        (fft_done),
    .pcm_done        (pcm_done),
    .pstate          (pstate),
    .pcm_rd_addr     (pcm_rd_addr),
    .pcm_rd_data     (pcm_rd_data),
    .bfly_cyc        (bfly_cyc),
    .bfly_stb        (bfly_stb),
    .bfly_a_real     (bfly_a_real),
    .bfly_a_im       (bfly_a_im),
    .bfly_b_real     (bfly_b_real),
    .bfly_b_im       (bfly_b_im),
    .bfly_ack        (bfly_ack),
    .bfly_a_real_res (bfly_a_real_res),
    .bfly_a_im_res   (bfly_a_im_res),
    .bfly_b_real_res (bfly_b_real_res),
    .bfly_b_im_res   (bfly_b_im_res),
    .res_wr_en       (res_wr_en),
    .res_wr_addr     (res_wr_addr),
    .res_wr_data     (res_wr_data)
  );

  initial
  begin
    clk_ir = 1'b0;
    forever #2 clk_ir = ~clk_ir;   // 4 ns period
  end

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (expected !== actual)
    begin
      $display("CHECK FAILED at %0t: %s, expected %h, got %h", $time, what, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests_run++;
    if (err_cnt == err_mark)
      $display("Test %-14s ok", name);
    else
    begin
      tests_failed++;
      $display("Test %-14s failed with %0d errors", name, err_cnt - err_mark);
    end
  endtask

  // One full run from the start pulse to the comparison of all results
  task automatic run_transform(input string name, input logic [3:0] code, input bit rand_ack);
    int err_mark;
    int runs_before;
    err_mark    = err_cnt;
    runs_before = runs_done;
    for (int k = 0; k < N; k++)
      pcm_mem[k] = $random(seed);
    ref_fft(pcm_mem, code, exp_res);
    ack_rand  = rand_ack;
    post_norm = code;
    fgyrus_en = 1'b1;
    pcm_rdy   = 1'b1;
    @(negedge clk_ir);
    pcm_rdy = 1'b0;
    while (runs_done == runs_before)
      @(negedge clk_ir);
    finish_test(name, err_mark);
  endtask

  // PCM RAM model with data RD_LAT cycles after its address
  always @(negedge clk_ir)
  begin
    pcm_rd_data <= rd_pipe[RD_LAT-1];
    for (int i = RD_LAT - 1; i > 0; i--)
      rd_pipe[i] <= rd_pipe[i-1];
    rd_pipe[0] <= pcm_mem[pcm_rd_addr];
  end

  // Butterfly slave that also watches the inputs hold until ack
  always @(negedge clk_ir)
  begin
    check_value(32'(bfly_cyc), 32'(bfly_stb), "bfly_stb against bfly_cyc");
    if (bfly_ack)
      bfly_ack <= 1'b0;
    else if (bfly_cyc && bfly_stb)
    begin
      if (!in_tx)
      begin
        in_tx    = 1'b1;
        ack_wait = ack_rand ? int'($unsigned($random(seed)) % 4) : 0;
        held[0]  = bfly_a_real;
        held[1]  = bfly_a_im;
        held[2]  = bfly_b_real;
        held[3]  = bfly_b_im;
        // Sums and differences of zero keep the imaginary parts at zero
        check_value(0, bfly_a_im, "bfly_a_im of a purely real input");
        check_value(0, bfly_b_im, "bfly_b_im of a purely real input");
      end
      else
      begin
        check_value(held[0], bfly_a_real, "bfly_a_real moved before ack");
        check_value(held[1], bfly_a_im, "bfly_a_im moved before ack");
        check_value(held[2], bfly_b_real, "bfly_b_real moved before ack");
        check_value(held[3], bfly_b_im, "bfly_b_im moved before ack");
      end
      if (ack_wait == 0)
      begin
        in_tx            = 1'b0;
        bfly_ack        <= 1'b1;
        bfly_a_real_res <= bfly_sum(bfly_a_real, bfly_b_real);
        bfly_a_im_res   <= bfly_sum(bfly_a_im, bfly_b_im);
        bfly_b_real_res <= bfly_diff(bfly_a_real, bfly_b_real);
        bfly_b_im_res   <= bfly_diff(bfly_a_im, bfly_b_im);
      end
      else
        ack_wait--;
    end
  end

  // Busy covers every phase except idle
  always @(negedge clk_ir)
  begin
    check_value(32'(pstate != IDLE_S), 32'(busy), "busy against the phase");
  end

  // PCM addresses in decimation
  always @(negedge clk_ir)
  begin
    if (pstate == DECIMATE_S)
    begin
      if (addr_seen < N)
      begin
        check_value(32'(bit_rev(addr_seen)), 32'(pcm_rd_addr), "PCM read address");
        addr_seen++;
      end
    end
    else if (addr_seen != 0)
    begin
      check_value(N, addr_seen, "PCM reads in decimation");
      addr_seen = 0;
    end
  end

  // Result RAM that is refilled with an address pattern while the next run loads
  always @(negedge clk_ir)
  begin
    if (pstate == DECIMATE_S)
    begin
      res_writes = 0;
      fft_pulses = 0;
      for (int k = 0; k < N; k++)
        res_mem[k] = 32'hdead_0000 | 32'(k);
    end
    if (fft_done)
      fft_pulses++;
    if (res_wr_en)
    begin
      res_mem[res_wr_addr] = res_wr_data;
      res_writes++;
    end
  end

  always @(negedge clk_ir)
  begin
    if (pcm_done)
    begin
      check_value(1, fft_pulses, "fft_done pulses before pcm_done");
      check_value(N, res_writes, "result RAM writes");
      for (int k = 0; k < N; k++)
        check_value(exp_res[k], res_mem[k], $sformatf("result at address %0d", k));
      runs_done++;
    end
  end

  initial
  begin
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge clk_ir);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT never finished its runs", MAX_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    int err_mark;
    rst_il    = 1'b0;
    fgyrus_en = 1'b0;
    pcm_rdy   = 1'b0;
    post_norm = 4'd0;
    for (int k = 0; k < N; k++)
      pcm_mem[k] = '0;
    repeat (16) @(negedge clk_ir);
    rst_il = 1'b1;

    err_mark = err_cnt;
    repeat (2) @(negedge clk_ir);
    check_value(0, 32'(busy), "busy after reset");
    check_value(0, 32'(fft_done), "fft_done after reset");
    check_value(0, 32'(pcm_done), "pcm_done after reset");
    check_value(0, 32'(res_wr_en), "res_wr_en after reset");
    check_value(0, 32'(bfly_cyc), "bfly_cyc after reset");
    check_value(32'(IDLE_S), 32'(pstate), "pstate after reset");
    finish_test("reset_state", err_mark);

    // Start pulse with the sequencer disabled
    err_mark = err_cnt;
    pcm_rdy  = 1'b1;
    @(negedge clk_ir);
    pcm_rdy = 1'b0;
    repeat (50)
    begin
      @(negedge clk_ir);
      check_value(0, 32'(busy), "busy with fgyrus_en low");
      check_value(0, 32'(bfly_cyc), "bfly_cyc with fgyrus_en low");
    end
    finish_test("enable_gating", err_mark);

    run_transform("transform", 4'd0, 1'b0);
    run_transform("norm_16", 4'd1, 1'b0);
    run_transform("norm_256", 4'd3, 1'b0);
    run_transform("norm_65536", 4'd5, 1'b0);
    run_transform("norm_illegal", 4'd9, 1'b0);   // Undefined code leaves data unshifted
    run_transform("back_pressure", 4'd0, 1'b1);

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- fgyrus_top.f
+incdir+sim
src/fgyrus_pkg.sv
src/cache_port_if.sv
src/fgyrus_ctrl.sv
src/pcm_loader.sv
src/butterfly_seq.sv
src/fft_cache.sv
src/result_writer.sv
src/fgyrus_top.sv
sim/fgyrus_tb.sv

//--- Makefile
# Verilator simulation of the FFT sequencer

TOP = fgyrus_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 -f fgyrus_top.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
